// File: bench/bldc_checker.sv
`timescale 1ns/1ps

module bldc_checker (
    input logic clk,
    input logic rst_n,
    input logic pready,
    input logic start,
    input logic done
);
    logic engine_busy;

    // the duty engine is occupied from a start until its done pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            engine_busy <= 1'b0;
        end else if (start) begin
            engine_busy <= 1'b1;
        end else if (done) begin
            engine_busy <= 1'b0;
        end
    end

    a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else $error("pready went low on a zero wait state slave");

    // the engine is back in idle on the cycle that carries done
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> (!engine_busy || done))
        else $error("start raised while the duty engine was busy");

    a_start_gap: assert property (@(posedge clk) disable iff (!rst_n)
        start |=> !start [*9])
        else $error("second start issued before the recompute finished");

    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ##9 done)
        else $error("done did not follow start after nine cycles");

    a_done_cause: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(start, 9))
        else $error("done pulse without a matching start");
endmodule

bind bldc_ctrl bldc_checker u_checker (
    .clk    (clk),
    .rst_n  (rst_n),
    .pready (pready),
    .start  (dif.start),
    .done   (dif.done)
);

// File: bench/bldc_tb.sv
`timescale 1ns/1ps
`include "bldc_cfg.svh"

module bldc_tb import bldc_pkg::*; ;
    localparam int N_RAND    = 8;
    localparam int PWM_CLKS  = `BLDC_PWM_PERIOD * `BLDC_PWM_PRESCALE;
    localparam int LEN_RESET = 300;
    localparam int LEN_REGS  = 300;
    localparam int LEN_RAND  = 2 * N_RAND * 200;
    localparam int LEN_PWM   = 2 * (3 * PWM_CLKS + 200);
    localparam int LEN_BURST = 200;
    localparam int LIMIT     = LEN_RESET + LEN_REGS + LEN_RAND + LEN_PWM + LEN_BURST + 1000;

    logic        clk;
    logic        rst_n;
    logic [5:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        en;
    logic        u;
    logic        v;
    logic        w;

    int          errors;
    int          checks;
    int          tests;
    int          cycle_cnt;
    logic [31:0] lfsr;

    clk_gen #(.PERIOD(8.0), .RST_CYCLES(16)) u_clk (.clk(clk), .rst_n(rst_n));

    bldc_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .en      (en),
        .u       (u),
        .v       (v),
        .w       (w)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // reference index: test mode uses the offset, closed loop adds feedback and torque
    function automatic int model_index(bit tm, logic [15:0] fb, logic [7:0] off,
                                       logic [7:0] tq, logic [15:0] vel, int ph);
        int fb_i;
        int off_i;
        int tq_i;
        int base;
        fb_i  = int'(fb);
        off_i = int'($signed(off));
        tq_i  = int'(tq);
        if (tm) begin
            base = off_i;
        end else if (vel[15]) begin
            base = fb_i / `BLDC_FB_DIV + off_i + tq_i;
        end else begin
            base = fb_i / `BLDC_FB_DIV + off_i - tq_i;
        end
        base = base + ph * (`BLDC_TLEN / 3);
        return ((base % `BLDC_TLEN) + `BLDC_TLEN) % `BLDC_TLEN;
    endfunction

    function automatic logic [7:0] model_duty(int idx, logic [15:0] vel);
        int vi;
        int mag;
        int d;
        vi  = int'($signed(vel));
        mag = (vi < 0) ? -vi : vi;
        if (mag > 255) mag = 255;
        d = int'(sine_table[idx]) * mag / `BLDC_DUTY_DIV;
        if (d > 255) d = 255;
        return d[7:0];
    endfunction

    task automatic check_duty(string name, logic [7:0] got, logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got 'h%0h, expected 'h%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got 'h%0h, expected 'h%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic apb_write(reg_addr_t a, logic [31:0] d);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = {a, 2'b00};
        pwdata  = d;
        penable = 1'b0;
        @(posedge clk);
        #1 penable = 1'b1;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(reg_addr_t a, output logic [31:0] d);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = {a, 2'b00};
        penable = 1'b0;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        d = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        int          polls;
        polls = 0;
        apb_read(STATUS, st);
        while (st[0] && polls < 100) begin
            polls++;
            apb_read(STATUS, st);
        end
        if (st[0]) begin
            errors++;
            $display("busy flag still set after %0d status reads at %0t", polls, $time);
        end
    endtask

    task automatic compare_duties(bit tm, logic [15:0] fb, logic [7:0] off,
                                  logic [7:0] tq, logic [15:0] vel);
        logic [31:0] rd;
        reg_addr_t   a;
        for (int ph = 0; ph < 3; ph++) begin
            a = reg_addr_t'(int'(DUTY_U) + ph);
            apb_read(a, rd);
            check_duty(a.name(), rd[7:0], model_duty(model_index(tm, fb, off, tq, vel, ph), vel));
            check_word({a.name(), " upper bits"}, {rd[31:8], 8'd0}, 32'd0);
        end
    endtask

    task automatic report_test(string name, int errs_before);
        tests++;
        $display("test %s finished with %0d errors", name, errors - errs_before);
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        reg_addr_t   a;
        int          e0;
        e0 = errors;
        for (int i = 0; i <= int'(DUTY_W); i++) begin
            a = reg_addr_t'(i);
            apb_read(a, rd);
            check_word(a.name(), rd, 32'd0);
        end
        repeat (100) begin
            @(negedge clk);
            check_bit("en", en, 1'b0);
            check_bit("u", u, 1'b0);
            check_bit("v", v, 1'b0);
            check_bit("w", w, 1'b0);
        end
        report_test("reset", e0);
    endtask

    task automatic test_regs();
        logic [31:0] vals [5];
        logic [31:0] masks [5];
        logic [31:0] rd;
        reg_addr_t   a;
        int          e0;
        e0    = errors;
        masks = '{32'h3, 32'hffff, 32'hff, 32'hff, 32'hffff};
        for (int i = 0; i < 5; i++) begin
            vals[i] = rand_bits(32);
            apb_write(reg_addr_t'(i), vals[i]);
        end
        for (int i = 0; i < 5; i++) begin
            a = reg_addr_t'(i);
            apb_read(a, rd);
            check_word(a.name(), rd, vals[i] & masks[i]);
        end
        wait_idle();
        apb_write(CTRL, 32'd0);
        wait_idle();
        report_test("register readback", e0);
    endtask

    task automatic test_open_loop();
        logic [7:0]  k;
        logic [15:0] vel;
        int          e0;
        e0 = errors;
        apb_write(CTRL, 32'h2);
        for (int i = 0; i < N_RAND; i++) begin
            k   = 8'(rand_bits(8));
            vel = 16'(rand_bits(16));
            apb_write(OFFSET, {24'd0, k});
            apb_write(VELOCITY, {16'd0, vel});
            wait_idle();
            compare_duties(1'b1, 16'd0, k, 8'd0, vel);
        end
        report_test("test mode duties", e0);
    endtask

    task automatic test_closed_loop();
        logic [15:0] fb;
        logic [7:0]  off;
        logic [7:0]  tq;
        logic [15:0] vel;
        int          e0;
        e0 = errors;
        apb_write(CTRL, 32'h0);
        for (int i = 0; i < N_RAND; i++) begin
            fb  = 16'(rand_bits(16));
            off = 8'(rand_bits(8));
            tq  = 8'(rand_bits(8));
            // even passes run in reverse, odd passes forward
            vel = {(i % 2 == 0), 15'(rand_bits(15))};
            apb_write(FEEDBACK, {16'd0, fb});
            apb_write(OFFSET, {24'd0, off});
            apb_write(TORQUE, {24'd0, tq});
            apb_write(VELOCITY, {16'd0, vel});
            wait_idle();
            compare_duties(1'b0, fb, off, tq, vel);
        end
        report_test("closed loop duties", e0);
    endtask

    task automatic pwm_window(logic [15:0] vel);
        int cnt [3];
        cnt = '{0, 0, 0};
        apb_write(VELOCITY, {16'd0, vel});
        wait_idle();
        repeat (2 * PWM_CLKS) @(posedge clk);
        repeat (PWM_CLKS) begin
            @(negedge clk);
            cnt[0] += u;
            cnt[1] += v;
            cnt[2] += w;
        end
        check_word("u high cycles", cnt[0],
                   32'(model_duty(model_index(1'b1, 16'd0, 8'd16, 8'd0, vel, 0), vel)) * 4);
        check_word("v high cycles", cnt[1],
                   32'(model_duty(model_index(1'b1, 16'd0, 8'd16, 8'd0, vel, 1), vel)) * 4);
        check_word("w high cycles", cnt[2],
                   32'(model_duty(model_index(1'b1, 16'd0, 8'd16, 8'd0, vel, 2), vel)) * 4);
    endtask

    task automatic test_pwm();
        int e0;
        e0 = errors;
        apb_write(OFFSET, 32'd16);
        apb_write(CTRL, 32'h3);
        check_bit("en", en, 1'b1);
        pwm_window(16'd100);
        pwm_window(16'd0);
        apb_write(CTRL, 32'h0);
        wait_idle();
        report_test("pwm outputs", e0);
    endtask

    task automatic test_burst();
        logic [31:0] rd;
        logic [7:0]  k;
        logic [15:0] vel_a;
        logic [15:0] vel_b;
        int          e0;
        e0    = errors;
        k     = 8'(rand_bits(8));
        vel_a = 16'(rand_bits(16));
        vel_b = 16'(rand_bits(16));
        apb_write(CTRL, 32'h2);
        wait_idle();
        apb_write(OFFSET, {24'd0, k});
        apb_write(VELOCITY, {16'd0, vel_a});
        apb_write(VELOCITY, {16'd0, vel_b});
        apb_read(STATUS, rd);
        check_word("STATUS after burst", rd, 32'd1);
        wait_idle();
        compare_duties(1'b1, 16'd0, k, 8'd0, vel_b);
        report_test("back to back writes", e0);
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= LIMIT) begin
            $display("run stopped after %0d cycles without finishing the tests", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        cycle_cnt = 0;
        lfsr      = 32'h1bc6_a849;
        @(posedge rst_n);
        test_reset();
        test_regs();
        test_open_loop();
        test_closed_loop();
        test_pwm();
        test_burst();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter real PERIOD     = 8.0,
    parameter int  RST_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // reset is released just after a rising edge so it never races the DUT flops
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end
endmodule

// File: tb.f
+incdir+verilog
verilog/bldc_pkg.sv
verilog/duty_if.sv
verilog/bldc_ctrl.sv
verilog/phase_angle.sv
verilog/duty_calc.sv
verilog/pwm_gen.sv
verilog/bldc_top.sv
bench/clk_gen.sv
bench/bldc_checker.sv
bench/bldc_tb.sv

// File: verilog/bldc_cfg.svh
`ifndef BLDC_CFG_SVH
`define BLDC_CFG_SVH

// length of the sine table, one electrical turn
`define BLDC_TLEN 64

// rotor feedback counts per table step
`define BLDC_FB_DIV 16

// clock cycles per PWM tick
`define BLDC_PWM_PRESCALE 4

// ticks per PWM period
`define BLDC_PWM_PERIOD 256

// the product of sine and magnitude is scaled down by this
`define BLDC_DUTY_DIV 100

`endif

// File: verilog/bldc_ctrl.sv
`timescale 1ns/1ps

module bldc_ctrl import bldc_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [5:0]        paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              en,
    output logic              testmode,
    output logic              direction,
    output logic signed [7:0] offset,
    output logic [7:0]        torque,
    output logic [15:0]       feedback,
    duty_if.ctrl              dif
);
    reg_addr_t          addr;
    logic               wr_en;
    logic               op_wr;
    logic signed [15:0] velocity;
    logic [15:0]        vel_abs;
    logic               req_q;
    logic               pending;
    logic               running;
    logic               launch;
    logic               busy;

    assign pready = 1'b1;
    assign addr   = reg_addr_t'(paddr[5:2]);
    assign wr_en  = psel && penable && pwrite;
    assign op_wr  = wr_en && (addr inside {CTRL, VELOCITY, OFFSET, TORQUE, FEEDBACK});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en       <= 1'b0;
            testmode <= 1'b0;
            velocity <= '0;
            offset   <= '0;
            torque   <= '0;
            feedback <= '0;
        end else if (wr_en) begin
            case (addr)
                CTRL: begin
                    en       <= pwdata[0];
                    testmode <= pwdata[1];
                end
                VELOCITY: velocity <= pwdata[15:0];
                OFFSET:   offset   <= pwdata[7:0];
                TORQUE:   torque   <= pwdata[7:0];
                FEEDBACK: feedback <= pwdata[15:0];
                default:  ;
            endcase
        end
    end

    // negative velocity means reverse rotation and the torque is added
    assign direction     = velocity[15];
    assign vel_abs       = velocity[15] ? 16'(-velocity) : velocity;
    assign dif.magnitude = (vel_abs > 16'd255) ? 8'd255 : vel_abs[7:0];

    // pending is set once the new indices are registered, start follows a cycle later
    assign launch = pending && (!running || dif.done);
    assign busy   = req_q || pending || running;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q     <= 1'b0;
            pending   <= 1'b0;
            running   <= 1'b0;
            dif.start <= 1'b0;
        end else begin
            req_q     <= op_wr;
            dif.start <= launch;
            if (launch) begin
                pending <= req_q;
                running <= 1'b1;
            end else begin
                if (req_q) begin
                    pending <= 1'b1;
                end
                if (dif.done) begin
                    running <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        case (addr)
            CTRL:     prdata = {30'd0, testmode, en};
            VELOCITY: prdata = {16'd0, velocity};
            OFFSET:   prdata = {24'd0, offset};
            TORQUE:   prdata = {24'd0, torque};
            FEEDBACK: prdata = {16'd0, feedback};
            STATUS:   prdata = {31'd0, busy};
            DUTY_U:   prdata = {24'd0, dif.duty_u};
            DUTY_V:   prdata = {24'd0, dif.duty_v};
            DUTY_W:   prdata = {24'd0, dif.duty_w};
            default:  prdata = '0;
        endcase
    end
endmodule

// File: verilog/bldc_pkg.sv
`include "bldc_cfg.svh"

package bldc_pkg;

    // word addresses, taken from paddr[5:2]
    typedef enum logic [3:0] {
        CTRL     = 4'd0,
        VELOCITY = 4'd1,
        OFFSET   = 4'd2,
        TORQUE   = 4'd3,
        FEEDBACK = 4'd4,
        STATUS   = 4'd5,
        DUTY_U   = 4'd6,
        DUTY_V   = 4'd7,
        DUTY_W   = 4'd8
    } reg_addr_t;

    typedef enum logic [1:0] {IDLE, LOAD, MULT, STORE} calc_state_t;

    // one sine period centred on 127
    localparam logic [7:0] sine_table [0:`BLDC_TLEN-1] = '{
        8'd127, 8'd139, 8'd151, 8'd163, 8'd175, 8'd186, 8'd197, 8'd207,
        8'd216, 8'd225, 8'd232, 8'd239, 8'd244, 8'd248, 8'd251, 8'd253,
        8'd254, 8'd253, 8'd251, 8'd248, 8'd244, 8'd239, 8'd232, 8'd225,
        8'd216, 8'd207, 8'd197, 8'd186, 8'd175, 8'd163, 8'd151, 8'd139,
        8'd127, 8'd114, 8'd102, 8'd90,  8'd78,  8'd67,  8'd56,  8'd46,
        8'd37,  8'd28,  8'd21,  8'd14,  8'd9,   8'd5,   8'd2,   8'd0,
        8'd0,   8'd0,   8'd2,   8'd5,   8'd9,   8'd14,  8'd21,  8'd28,
        8'd37,  8'd46,  8'd56,  8'd67,  8'd78,  8'd90,  8'd102, 8'd114
    };

endpackage

// File: verilog/bldc_top.sv
`timescale 1ns/1ps

module bldc_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [5:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        en,
    output logic        u,
    output logic        v,
    output logic        w
);
    logic              testmode;
    logic              direction;
    logic signed [7:0] offset;
    logic [7:0]        torque;
    logic [15:0]       feedback;

    duty_if dif ();

    bldc_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .en        (en),
        .testmode  (testmode),
        .direction (direction),
        .offset    (offset),
        .torque    (torque),
        .feedback  (feedback),
        .dif       (dif.ctrl)
    );

    phase_angle u_angle (
        .clk       (clk),
        .rst_n     (rst_n),
        .testmode  (testmode),
        .direction (direction),
        .offset    (offset),
        .torque    (torque),
        .feedback  (feedback),
        .dif       (dif.angle)
    );

    duty_calc u_calc (
        .clk   (clk),
        .rst_n (rst_n),
        .dif   (dif.calc)
    );

    pwm_gen u_pwm (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .dif   (dif.pwm),
        .u     (u),
        .v     (v),
        .w     (w)
    );
endmodule

// File: verilog/duty_calc.sv
`timescale 1ns/1ps
`include "bldc_cfg.svh"

module duty_calc import bldc_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    duty_if.calc dif
);
    localparam logic [15:0] DUTY_MAX = 16'd255;

    calc_state_t state;
    logic [1:0]  phase;
    logic [7:0]  mag_q;
    logic [5:0]  idx_v_q;
    logic [5:0]  idx_w_q;
    logic [7:0]  sine_q;
    logic [15:0] prod_q;
    logic [15:0] prod_sum;
    logic [15:0] quot;
    logic [7:0]  duty_new;

    // each set bit of the sine value adds a shifted copy of the magnitude
    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < 8; i++) begin
            if (sine_q[i]) begin
                prod_sum = prod_sum + ({8'd0, mag_q} << i);
            end
        end
    end

    assign quot     = prod_q / 16'(`BLDC_DUTY_DIV);
    // products of 25600 and above clip the duty at full scale
    assign duty_new = (quot > DUTY_MAX) ? DUTY_MAX[7:0] : quot[7:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            phase      <= 2'd0;
            dif.done   <= 1'b0;
            dif.duty_u <= 8'd0;
            dif.duty_v <= 8'd0;
            dif.duty_w <= 8'd0;
        end else begin
            dif.done <= 1'b0;
            case (state)
                IDLE: begin
                    if (dif.start) begin
                        phase <= 2'd0;
                        state <= MULT;
                    end
                end
                LOAD: state <= MULT;
                MULT: state <= STORE;
                STORE: begin
                    case (phase)
                        2'd0:    dif.duty_u <= duty_new;
                        2'd1:    dif.duty_v <= duty_new;
                        default: dif.duty_w <= duty_new;
                    endcase
                    if (phase == 2'd2) begin
                        dif.done <= 1'b1;
                        state    <= IDLE;
                    end else begin
                        phase <= phase + 2'd1;
                        state <= LOAD;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the u fetch happens on the start edge so every phase takes three cycles
    always_ff @(posedge clk) begin
        if (state == IDLE && dif.start) begin
            mag_q   <= dif.magnitude;
            idx_v_q <= dif.idx_v;
            idx_w_q <= dif.idx_w;
            sine_q  <= sine_table[dif.idx_u];
        end else if (state == LOAD) begin
            sine_q <= (phase == 2'd1) ? sine_table[idx_v_q] : sine_table[idx_w_q];
        end
        if (state == MULT) begin
            prod_q <= prod_sum;
        end
    end
endmodule

// File: verilog/duty_if.sv
`timescale 1ns/1ps

interface duty_if;
    logic       start;
    logic [7:0] magnitude;
    logic [5:0] idx_u;
    logic [5:0] idx_v;
    logic [5:0] idx_w;
    logic       done;
    logic [7:0] duty_u;
    logic [7:0] duty_v;
    logic [7:0] duty_w;

    modport ctrl (output start, output magnitude,
                  input done, input duty_u, input duty_v, input duty_w);

    modport angle (output idx_u, output idx_v, output idx_w);

    modport calc (input start, input magnitude, input idx_u, input idx_v, input idx_w,
                  output done, output duty_u, output duty_v, output duty_w);

    modport pwm (input done, input duty_u, input duty_v, input duty_w);
endinterface

// File: verilog/phase_angle.sv
`timescale 1ns/1ps
`include "bldc_cfg.svh"

module phase_angle (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              testmode,
    input  logic              direction,
    input  logic signed [7:0] offset,
    input  logic [7:0]        torque,
    input  logic [15:0]       feedback,
    duty_if.angle             dif
);
    localparam logic [5:0] TOFF_V = 6'(`BLDC_TLEN / 3);
    localparam logic [5:0] TOFF_W = 6'(`BLDC_TLEN / 3 * 2);

    logic [5:0] fb_idx;
    logic [5:0] base;

    // only the low six bits matter since the index wraps around the table
    assign fb_idx = 6'(feedback / `BLDC_FB_DIV);

    always_comb begin
        if (testmode) begin
            base = offset[5:0];
        end else if (direction) begin
            base = fb_idx + offset[5:0] + torque[5:0];
        end else begin
            base = fb_idx + offset[5:0] - torque[5:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dif.idx_u <= '0;
            dif.idx_v <= '0;
            dif.idx_w <= '0;
        end else begin
            dif.idx_u <= base;
            dif.idx_v <= base + TOFF_V;
            dif.idx_w <= base + TOFF_W;
        end
    end
endmodule

// File: verilog/pwm_gen.sv
`timescale 1ns/1ps
`include "bldc_cfg.svh"

module pwm_gen (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    duty_if.pwm  dif,
    output logic u,
    output logic v,
    output logic w
);
    localparam int PS_W  = $clog2(`BLDC_PWM_PRESCALE);
    localparam int CNT_W = $clog2(`BLDC_PWM_PERIOD);

    logic [PS_W-1:0]  ps_cnt;
    logic [CNT_W-1:0] period_cnt;
    logic             tick;
    logic             wrap;
    logic [7:0]       pend_u;
    logic [7:0]       pend_v;
    logic [7:0]       pend_w;
    logic [7:0]       shd_u;
    logic [7:0]       shd_v;
    logic [7:0]       shd_w;

    assign tick = en && (ps_cnt == PS_W'(`BLDC_PWM_PRESCALE - 1));
    assign wrap = tick && (period_cnt == CNT_W'(`BLDC_PWM_PERIOD - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ps_cnt     <= '0;
            period_cnt <= '0;
            pend_u     <= 8'd0;
            pend_v     <= 8'd0;
            pend_w     <= 8'd0;
            shd_u      <= 8'd0;
            shd_v      <= 8'd0;
            shd_w      <= 8'd0;
            u          <= 1'b0;
            v          <= 1'b0;
            w          <= 1'b0;
        end else begin
            // counters sit at zero while disabled
            ps_cnt     <= en ? ps_cnt + PS_W'(1) : '0;
            period_cnt <= !en ? '0 : (tick ? period_cnt + CNT_W'(1) : period_cnt);
            if (dif.done) begin
                pend_u <= dif.duty_u;
                pend_v <= dif.duty_v;
                pend_w <= dif.duty_w;
            end
            if (wrap) begin
                shd_u <= pend_u;
                shd_v <= pend_v;
                shd_w <= pend_w;
            end
            u <= en && (period_cnt < shd_u);
            v <= en && (period_cnt < shd_v);
            w <= en && (period_cnt < shd_w);
        end
    end
endmodule
